// ==== filelist.f ====
rtl/mul_types_pkg.sv
rtl/mul_op_pkg.sv
rtl/mul_reduce_if.sv
rtl/booth_pp_stage.sv
rtl/csa_tree_stage.sv
rtl/final_add_stage.sv
rtl/wallace_mul_top.sv
tb/tb_wallace_mul.sv

// ==== run.sh ====
#!/bin/sh
# build and run the multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_wallace_mul \
    -f filelist.f \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"

// ==== tb/tb_wallace_mul.sv ====
// testbench for the booth/wallace multiplier with random and corner operands and a queue scoreboard
`timescale 1ns/1ns

module tb_wallace_mul;

    localparam int XW = mul_types_pkg::XLEN;
    localparam int WW = mul_op_pkg::WORD_W;
    localparam int RESET_CYCLES = 8;
    localparam int N_FULL = 64;
    localparam int N_WORD = 32;
    localparam int N_CORNER = 5;
    localparam int N_BURST = 16;
    localparam int NUM_OPS = 4 * N_FULL + 4 * N_WORD + 2 * 4 * N_CORNER * N_CORNER + N_BURST;
    // every op may be preceded by one idle cycle
    localparam int MAX_CYCLES = RESET_CYCLES + 2 * NUM_OPS + 50;

    logic          clk;
    logic          rst;
    logic          in_valid;
    logic          word;
    logic          a_signed;
    logic          b_signed;
    logic [XW-1:0] multiplicand;
    logic [XW-1:0] multiplier;
    logic          out_valid;
    logic [XW-1:0] result_hi;
    logic [XW-1:0] result_lo;

    logic [XW-1:0] exp_hi_q [$];
    logic [XW-1:0] exp_lo_q [$];
    int            exp_cyc_q [$];
    logic [XW-1:0] corners [N_CORNER];

    int            cyc = 0;
    int            value_errors = 0;
    int            protocol_errors = 0;
    int            results_checked = 0;

    wallace_mul_top DUT (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .word         (word),
        .a_signed     (a_signed),
        .b_signed     (b_signed),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .out_valid    (out_valid),
        .result_hi    (result_hi),
        .result_lo    (result_lo)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d results never arrived", cyc, exp_lo_q.size());
            $display(">>> FAIL");
            $finish;
        end
    end

    // ======================================================================
    // reference model giving {hi, lo} as the DUT should return them
    function automatic logic [2*XW-1:0] model_result(
        input logic [XW-1:0] a,
        input logic [XW-1:0] b,
        input logic          as,
        input logic          bs,
        input logic          wm
    );
        logic [2*XW-1:0] ax;
        logic [2*XW-1:0] bx;
        logic [XW-1:0]   wp;
        if (wm) begin
            wp = {{(XW-WW){1'b0}}, a[WW-1:0]} * {{(XW-WW){1'b0}}, b[WW-1:0]};
            return {{XW{1'b0}}, {(XW-WW){wp[WW-1]}}, wp[WW-1:0]};
        end
        ax = {{XW{as & a[XW-1]}}, a};
        bx = {{XW{bs & b[XW-1]}}, b};
        return ax * bx;
    endfunction

    function automatic logic [XW-1:0] rand_operand();
        return {$urandom, $urandom};
    endfunction

    // ======================================================================
    // scoreboard check once per falling edge before new inputs go out
    task automatic check_outputs();
        logic [XW-1:0] eh;
        logic [XW-1:0] el;
        int            ec;
        if (out_valid !== 1'b0 && out_valid !== 1'b1) begin
            $display("out_valid is unknown at %0t", $time);
            protocol_errors++;
        end else if (out_valid) begin
            if (exp_lo_q.size() == 0) begin
                $display("out_valid high at %0t with no operation in flight", $time);
                protocol_errors++;
            end else begin
                eh = exp_hi_q.pop_front();
                el = exp_lo_q.pop_front();
                ec = exp_cyc_q.pop_front();
                results_checked++;
                if (ec != cyc) begin
                    $display("result came at cycle %0d but was due at cycle %0d", cyc, ec);
                    protocol_errors++;
                end
                if (result_hi !== eh) begin
                    $display("FAIL %0t result_hi %h, expected %h", $time, result_hi, eh);
                    value_errors++;
                end
                if (result_lo !== el) begin
                    $display("FAIL %0t result_lo %h, expected %h", $time, result_lo, el);
                    value_errors++;
                end
            end
        end else if (exp_cyc_q.size() > 0 && exp_cyc_q[0] <= cyc) begin
            $display("no out_valid at cycle %0d for an operation due then", cyc);
            protocol_errors++;
            void'(exp_hi_q.pop_front());
            void'(exp_lo_q.pop_front());
            void'(exp_cyc_q.pop_front());
        end
    endtask

    task automatic issue(
        input logic          v,
        input logic          wm,
        input logic          as,
        input logic          bs,
        input logic [XW-1:0] a,
        input logic [XW-1:0] b
    );
        logic [2*XW-1:0] e;
        @(negedge clk);
        check_outputs();
        in_valid     = v;
        word         = wm;
        a_signed     = as;
        b_signed     = bs;
        multiplicand = a;
        multiplier   = b;
        if (v) begin
            e = model_result(a, b, as, bs, wm);
            exp_hi_q.push_back(e[2*XW-1:XW]);
            exp_lo_q.push_back(e[XW-1:0]);
            exp_cyc_q.push_back(cyc + mul_op_pkg::PIPE_LAT);
        end
    endtask

    // operands keep moving while in_valid is low
    task automatic idle_cycle();
        issue(1'b0, 1'b0, 1'b0, 1'b0, rand_operand(), rand_operand());
    endtask

    task automatic random_op(input logic wm, input logic as, input logic bs);
        if ($urandom % 4 == 0) begin
            idle_cycle();
        end
        issue(1'b1, wm, as, bs, rand_operand(), rand_operand());
    endtask

    // ======================================================================
    // stimulus
    initial begin
        void'($urandom(32'hefad6ca3));
        rst = 1'b1;
        in_valid = 1'b0;
        word = 1'b0;
        a_signed = 1'b0;
        b_signed = 1'b0;
        multiplicand = '0;
        multiplier = '0;
        corners[0] = '0;
        corners[1] = '1;
        corners[2] = {1'b1, {(XW-1){1'b0}}};
        corners[3] = {{(XW-1){1'b0}}, 1'b1};
        corners[4] = {{(XW-WW){1'b0}}, 1'b1, {(WW-1){1'b0}}};

        // out_valid must stay low through reset
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_outputs();
        end
        rst = 1'b0;
        repeat (3) idle_cycle();

        for (int c = 0; c < 4; c++) begin
            for (int i = 0; i < N_FULL; i++) begin
                random_op(1'b0, c[1], c[0]);
            end
        end
        for (int c = 0; c < 4; c++) begin
            for (int i = 0; i < N_WORD; i++) begin
                random_op(1'b1, c[1], c[0]);
            end
        end

        // corner pairs issued back to back
        for (int m = 0; m < 2; m++) begin
            for (int c = 0; c < 4; c++) begin
                for (int i = 0; i < N_CORNER; i++) begin
                    for (int j = 0; j < N_CORNER; j++) begin
                        issue(1'b1, m[0], c[1], c[0], corners[i], corners[j]);
                    end
                end
            end
        end

        // mixed burst with the mode changing every cycle
        for (int i = 0; i < N_BURST; i++) begin
            issue(1'b1, i[0], i[1], i[2], rand_operand(), rand_operand());
        end

        while (exp_lo_q.size() > 0) begin
            idle_cycle();
        end
        repeat (mul_op_pkg::PIPE_LAT + 2) idle_cycle();

        $display("results checked %0d, value errors %0d, protocol errors %0d",
                 results_checked, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0 && results_checked == NUM_OPS) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== rtl/wallace_mul_top.sv ====
// 64-bit booth/wallace multiplier, two-register pipeline with valid in and out
`timescale 1ns/1ns

module wallace_mul_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  logic                 word,
    input  logic                 a_signed,
    input  logic                 b_signed,
    input  mul_types_pkg::xlen_t multiplicand,
    input  mul_types_pkg::xlen_t multiplier,
    output logic                 out_valid,
    output mul_types_pkg::xlen_t result_hi,
    output mul_types_pkg::xlen_t result_lo
);

    logic                 pp_valid;
    logic                 pp_word;
    mul_types_pkg::prod_t pp_rows [mul_op_pkg::TREE_ROWS];

    mul_reduce_if red_if ();

    // ======================================================================
    // stage 1, booth rows
    booth_pp_stage u_booth (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .word         (word),
        .a_signed     (a_signed),
        .b_signed     (b_signed),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .pp_valid     (pp_valid),
        .pp_word      (pp_word),
        .pp_rows      (pp_rows)
    );

    // stage 2, reduction tree
    csa_tree_stage u_tree (
        .clk      (clk),
        .rst      (rst),
        .pp_valid (pp_valid),
        .pp_word  (pp_word),
        .pp_rows  (pp_rows),
        .red      (red_if.producer)
    );

    // combinational final add
    final_add_stage u_add (
        .red       (red_if.consumer),
        .out_valid (out_valid),
        .result_hi (result_hi),
        .result_lo (result_lo)
    );

endmodule

// ==== rtl/final_add_stage.sv ====
// output stage: carry-propagate add of sum and carry, word-mode formatting
`timescale 1ns/1ns

module final_add_stage (
    mul_reduce_if.consumer       red,
    output logic                 out_valid,
    output mul_types_pkg::xlen_t result_hi,
    output mul_types_pkg::xlen_t result_lo
);

    mul_types_pkg::prod_t product;

    // single wide adder, the only carry chain in the design
    assign product = red.sum + red.carry;

    assign out_valid = red.valid;

    always_comb begin
        if (red.word) begin
            // low word sign-extended, high half unused
            result_hi = '0;
            result_lo = {{(mul_types_pkg::XLEN - mul_op_pkg::WORD_W){product[mul_op_pkg::WORD_W-1]}},
                         product[mul_op_pkg::WORD_W-1:0]};
        end else begin
            result_hi = product[2*mul_types_pkg::XLEN-1 : mul_types_pkg::XLEN];
            result_lo = product[mul_types_pkg::XLEN-1:0];
        end
    end

endmodule

// ==== rtl/csa_tree_stage.sv ====
// second pipeline stage that reduces all rows to a sum/carry pair in carry-save form
`timescale 1ns/1ns

module csa_tree_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pp_valid,
    input  logic                 pp_word,
    input  mul_types_pkg::prod_t pp_rows [mul_op_pkg::TREE_ROWS],
    mul_reduce_if.producer       red
);

    // rows left after a number of 3:2 levels
    function automatic int rows_at(input int lv);
        int n;
        n = mul_op_pkg::TREE_ROWS;
        for (int k = 0; k < lv; k++) begin
            n = 2 * (n / 3) + n % 3;
        end
        return n;
    endfunction

    // levels until only sum and carry remain
    function automatic int tree_levels();
        int lv;
        lv = 0;
        while (rows_at(lv) > 2) begin
            lv++;
        end
        return lv;
    endfunction

    // level 0 holds the registered booth rows and the last level two rows
    mul_types_pkg::prod_t lvl [tree_levels() + 1][mul_op_pkg::TREE_ROWS];

    // plain sum of all rows which the tree must preserve
    mul_types_pkg::prod_t row_total;

    for (genvar r = 0; r < mul_op_pkg::TREE_ROWS; r++) begin : g_in
        assign lvl[0][r] = pp_rows[r];
    end

    // ======================================================================
    // wallace levels
    for (genvar lv = 0; lv < tree_levels(); lv++) begin : g_lvl
        // full adders on each group of three rows
        for (genvar g = 0; g < rows_at(lv) / 3; g++) begin : g_csa
            mul_types_pkg::prod_t x;
            mul_types_pkg::prod_t y;
            mul_types_pkg::prod_t z;

            assign x = lvl[lv][3*g];
            assign y = lvl[lv][3*g+1];
            assign z = lvl[lv][3*g+2];

            assign lvl[lv+1][2*g]   = x ^ y ^ z;
            // carry out of the top column falls off since the product fits below it
            assign lvl[lv+1][2*g+1] = ((x & y) | (x & z) | (y & z)) << 1;
        end

        // leftover rows go straight to the next level
        for (genvar p = 0; p < rows_at(lv) % 3; p++) begin : g_pass
            assign lvl[lv+1][2*(rows_at(lv)/3) + p] = lvl[lv][3*(rows_at(lv)/3) + p];
        end
    end

    always_comb begin
        row_total = '0;
        for (int r = 0; r < mul_op_pkg::TREE_ROWS; r++) begin
            row_total = row_total + pp_rows[r];
        end
    end

    // ======================================================================
    // stage register
    always_ff @(posedge clk) begin
        if (rst) begin
            red.valid <= 1'b0;
        end else begin
            red.valid <= pp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pp_valid) begin
            red.sum   <= lvl[tree_levels()][0];
            red.carry <= lvl[tree_levels()][1];
            red.word  <= pp_word;
        end
    end

    a_tree_keeps_sum: assert property (@(posedge clk) disable iff (rst)
        pp_valid |-> (lvl[tree_levels()][0] + lvl[tree_levels()][1] == row_total));

endmodule

// ==== rtl/booth_pp_stage.sv ====
// first pipeline stage: operand extension, radix-4 booth rows and row register
`timescale 1ns/1ns

module booth_pp_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  logic                 word,
    input  logic                 a_signed,
    input  logic                 b_signed,
    input  mul_types_pkg::xlen_t multiplicand,
    input  mul_types_pkg::xlen_t multiplier,
    output logic                 pp_valid,
    output logic                 pp_word,
    output mul_types_pkg::prod_t pp_rows [mul_op_pkg::TREE_ROWS]
);

    // upper bits come from bit 31 in word mode, bit 63 otherwise, or zero
    function automatic mul_types_pkg::ext_t extend(
        input mul_types_pkg::xlen_t v,
        input logic                 sgn,
        input logic                 wmode
    );
        logic fill;
        if (wmode) begin
            fill = sgn & v[mul_op_pkg::WORD_W-1];
            return {{(mul_types_pkg::EXT_W - mul_op_pkg::WORD_W){fill}},
                    v[mul_op_pkg::WORD_W-1:0]};
        end
        fill = sgn & v[mul_types_pkg::XLEN-1];
        return {{(mul_types_pkg::EXT_W - mul_types_pkg::XLEN){fill}}, v};
    endfunction

    mul_types_pkg::ext_t  a_ext;
    mul_types_pkg::ext_t  b_ext;
    mul_types_pkg::prod_t a_wide;
    logic [mul_types_pkg::EXT_W:0]      b_pad;
    logic [mul_op_pkg::PP_ROWS-1:0]     neg;
    mul_types_pkg::prod_t corr;
    mul_types_pkg::prod_t rows_d [mul_op_pkg::TREE_ROWS];

    assign a_ext  = extend(multiplicand, a_signed, word);
    assign b_ext  = extend(multiplier, b_signed, word);
    assign a_wide = {{(mul_types_pkg::PROD_W - mul_types_pkg::EXT_W){a_ext[mul_types_pkg::EXT_W-1]}},
                     a_ext};
    // implicit zero below bit 0 for the first booth triplet
    assign b_pad  = {b_ext, 1'b0};

    // ======================================================================
    // booth rows
    for (genvar i = 0; i < mul_op_pkg::PP_ROWS; i++) begin : g_row
        logic [2:0]           sel;
        mul_types_pkg::prod_t mag;

        assign sel = b_pad[2*i +: 3];

        always_comb begin
            case (sel)
                3'b001, 3'b010, 3'b101, 3'b110: mag = a_wide;
                3'b011, 3'b100:                 mag = a_wide << 1;
                default:                        mag = '0;
            endcase
        end

        // -x taken as ~x here, the +1 goes into the correction row
        assign neg[i]    = sel[2] & ~(sel[1] & sel[0]);
        assign rows_d[i] = (neg[i] ? ~mag : mag) << (2 * i);
    end

    always_comb begin
        corr = '0;
        for (int i = 0; i < mul_op_pkg::PP_ROWS; i++) begin
            corr[2*i] = neg[i];
        end
    end

    assign rows_d[mul_op_pkg::TREE_ROWS-1] = corr;

    // ======================================================================
    // stage register
    always_ff @(posedge clk) begin
        if (rst) begin
            pp_valid <= 1'b0;
        end else begin
            pp_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            pp_rows <= rows_d;
            pp_word <= word;
        end
    end

    a_pp_valid_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(pp_valid));

endmodule

// ==== rtl/mul_reduce_if.sv ====
// carry-save result link from the reduction tree to the final adder
`timescale 1ns/1ns

interface mul_reduce_if;

    logic                 valid;
    mul_types_pkg::prod_t sum;
    mul_types_pkg::prod_t carry;
    logic                 word;

    // tree side, registered values
    modport producer (
        output valid,
        output sum,
        output carry,
        output word
    );

    // adder side
    modport consumer (
        input valid,
        input sum,
        input carry,
        input word
    );

endinterface

// ==== rtl/mul_op_pkg.sv ====
// multiplier operation constants: word width, booth row count and pipeline depth
package mul_op_pkg;

    // word-mode operands use the low half of each register
    localparam int WORD_W = 32;

    // radix-4 booth retires two multiplier bits per row
    localparam int PP_ROWS = mul_types_pkg::EXT_W / 2;

    // booth rows plus the row holding all negation bits
    localparam int TREE_ROWS = PP_ROWS + 1;

    // input sample to out_valid, in clock edges
    localparam int PIPE_LAT = 2;

endpackage

// ==== rtl/mul_types_pkg.sv ====
// multiplier datapath types: operand, extended operand and product row widths
package mul_types_pkg;

    // ======================================================================
    // widths

    // one operand or one result half
    localparam int XLEN = 64;

    // operand plus two copies of the sign bit, so unsigned values stay positive
    localparam int EXT_W = XLEN + 2;

    // full product of two extended operands
    localparam int PROD_W = 2 * EXT_W;

    // ======================================================================
    // vector types

    typedef logic [XLEN-1:0] xlen_t;

    typedef logic [EXT_W-1:0] ext_t;

    // one partial-product row, or the reduced sum / carry vector
    typedef logic [PROD_W-1:0] prod_t;

endpackage
